//--- compile.f
rtl/erx_pkg.sv
rtl/erx_io.sv
rtl/erx_frame_detect.sv
rtl/erx_decoder.sv
rtl/erx_top.sv
verification/erx_properties.sv
verification/erx_tb.sv

//--- rtl/erx_decoder.sv
`timescale 1ns/10ps

module erx_decoder
  (
   input  logic                              rx_lclk,
   input  logic                              rst_n,
   // from erx_io
   input  logic [erx_pkg::ERX_WORD_BITS-1:0] rx_data_par,
   input  logic                              rx_par_valid,
   // from erx_frame_detect
   input  logic                              pkt_start,
   input  logic [erx_pkg::ERX_CNT_BITS-1:0]  pkt_off,
   // decoded transaction
   output logic                              rx_access,    // one pulse per packet
   output logic                              rx_write,
   output logic [1:0]                        rx_datamode,
   output logic [3:0]                        rx_ctrlmode,
   output logic [31:0]                       rx_dstaddr,
   output logic [31:0]                       rx_wdata,     // zero on reads
   output erx_pkg::erx_rd_src_t              rx_rd_src     // zero on writes
  );

   import erx_pkg::*;

   localparam int PKT_BITS = ERX_PKT_BYTES * ERX_LANES;

   logic [ERX_WORD_BITS-1:0]   word_prev;   // word holding the packet start
   logic [ERX_WORD_BITS-1:0]   word_cur;    // word holding the packet end
   logic [2*ERX_WORD_BITS-1:0] window;      // 16 bytes, byte 0 oldest
   logic [PKT_BITS-1:0]        pkt_bits;
   logic [ERX_LANES-1:0]       pkt_byte [ERX_PKT_BYTES];
   logic [ERX_LANES-1:0]       hdr;
   logic [31:0]                dstaddr;
   erx_payload_u               payload;
   logic                       hdr_write;

   //####################################################################
   // two-word window
   //####################################################################

   // pkt_start for the previous word arrives one cycle after this update
   always_ff @(posedge rx_lclk)
   begin
      if (rx_par_valid)
      begin
         word_prev <= word_cur;
         word_cur  <= rx_data_par;
      end
   end

   assign window   = {word_cur, word_prev};
   assign pkt_bits = window[pkt_off * ERX_LANES +: PKT_BITS];  // bytes off..off+8

   //####################################################################
   // field split
   //####################################################################

   always_comb
   begin
      for (int m = 0; m < ERX_PKT_BYTES; m++)
      begin
         pkt_byte[m] = pkt_bits[m*ERX_LANES +: ERX_LANES];
      end
   end

   assign hdr       = pkt_byte[0];
   assign hdr_write = hdr[ERX_HDR_WRITE];
   assign dstaddr   = {pkt_byte[1], pkt_byte[2], pkt_byte[3], pkt_byte[4]};  // msb first

   // same four bytes, read as wdata or as rd_src
   assign payload.wdata = {pkt_byte[5], pkt_byte[6], pkt_byte[7], pkt_byte[8]};

   //####################################################################
   // output registers
   //####################################################################

   always_ff @(posedge rx_lclk)
   begin
      if (!rst_n)
      begin
         rx_access <= 1'b0;
      end
      else
      begin
         rx_access <= pkt_start;
      end
   end

   // fields are only valid with rx_access
   always_ff @(posedge rx_lclk)
   begin
      if (pkt_start)
      begin
         rx_write    <= hdr_write;
         rx_datamode <= hdr[ERX_HDR_DM_MSB:ERX_HDR_DM_LSB];
         rx_ctrlmode <= hdr[ERX_HDR_CTRL_MSB:ERX_HDR_CTRL_LSB];
         rx_dstaddr  <= dstaddr;
         if (hdr_write)
         begin
            rx_wdata  <= payload.wdata;
            rx_rd_src <= '0;
         end
         else
         begin
            rx_wdata  <= '0;
            rx_rd_src <= payload.rd_src;  // row, col, offset of the requester
         end
      end
   end

endmodule

//--- rtl/erx_frame_detect.sv
`timescale 1ns/10ps

module erx_frame_detect
  (
   input  logic                              rx_lclk,
   input  logic                              rst_n,
   input  logic                              rxi_frame,     // frame lane pin
   input  logic                              rx_par_valid,  // word strobe from erx_io
   output logic                              pkt_start,     // packet began in previous word
   output logic [erx_pkg::ERX_CNT_BITS-1:0]  pkt_off,       // first byte of that packet
   output logic                              rx_frame_err   // frame dropped before byte 9
  );

   import erx_pkg::*;

   localparam int HIST_BITS = 2 * ERX_WORD_BYTES;  // previous + current word

   logic [HIST_BITS-1:0]    frame_hist;   // [7:0] previous word, [15:8] current word
   logic                    frame_prior;  // last frame bit of the word before previous
   logic [HIST_BITS:0]      frame_ext;    // history with the prior bit underneath
   logic                    edge_found;
   logic [ERX_CNT_BITS-1:0] edge_off;
   logic [ERX_PKT_BYTES-1:0] frame_run;   // frame bits over the nine packet bytes
   logic                    frame_full;

   //####################################################################
   // frame history
   //####################################################################

   // shifts on every sample, same byte order as the data word
   always_ff @(posedge rx_lclk)
   begin
      if (!rst_n)
      begin
         frame_hist  <= '0;     // idle link, no edge right after reset
         frame_prior <= 1'b0;
      end
      else
      begin
         frame_hist <= {rxi_frame, frame_hist[HIST_BITS-1:1]};
         if (rx_par_valid)
         begin
            frame_prior <= frame_hist[ERX_WORD_BYTES-1];  // becomes the edge reference
         end
      end
   end

   assign frame_ext = {frame_hist, frame_prior};

   //####################################################################
   // start finder
   //####################################################################

   // low to high inside the previous word, bit k+1 of ext is byte k
   always_comb
   begin
      edge_found = 1'b0;
      edge_off   = '0;
      for (int k = ERX_WORD_BYTES - 1; k >= 0; k--)  // lowest offset written last
      begin
         if (frame_ext[k+1] && !frame_ext[k])
         begin
            edge_found = 1'b1;
            edge_off   = ERX_CNT_BITS'(k);
         end
      end
   end

   // a start at offset 7 still ends at byte 15, inside the history
   assign frame_run  = frame_hist[edge_off +: ERX_PKT_BYTES];
   assign frame_full = &frame_run;

   //####################################################################
   // result, one cycle after the strobe
   //####################################################################

   always_ff @(posedge rx_lclk)
   begin
      if (!rst_n)
      begin
         pkt_start    <= 1'b0;
         rx_frame_err <= 1'b0;
      end
      else
      begin
         pkt_start    <= rx_par_valid & edge_found & frame_full;
         rx_frame_err <= rx_par_valid & edge_found & ~frame_full;  // short frame
      end
   end

   always_ff @(posedge rx_lclk)
   begin
      if (rx_par_valid)
      begin
         pkt_off <= edge_off;  // only looked at with pkt_start
      end
   end

endmodule

//--- rtl/erx_io.sv
`timescale 1ns/10ps

module erx_io
  (
   input  logic                               rx_lclk,       // link sample clock
   input  logic                               rst_n,
   // link pins
   input  logic [erx_pkg::ERX_LANES-1:0]      rxi_data,      // one byte per sample
   output logic                               rxo_wr_wait,   // write pushback to sender
   output logic                               rxo_rd_wait,   // read pushback to sender
   // fabric side
   input  logic                               rx_wr_wait,
   input  logic                               rx_rd_wait,
   output logic [erx_pkg::ERX_WORD_BITS-1:0]  rx_data_par,   // byte n at [8n+7:8n]
   output logic                               rx_par_valid   // one pulse per word
  );

   import erx_pkg::*;

   //####################################################################
   // deserializer
   //####################################################################

   logic [ERX_CNT_BITS-1:0]            sample_cnt;  // byte position of the live sample
   logic [ERX_WORD_BITS-ERX_LANES-1:0] lane_sh;     // bytes 0..6 of the word in flight
   logic                               word_done;   // live sample is the last byte

   assign word_done = (sample_cnt == ERX_CNT_BITS'(ERX_WORD_BYTES - 1));

   // sample counter and word strobe
   always_ff @(posedge rx_lclk)
   begin
      if (!rst_n)
      begin
         sample_cnt   <= '0;    // first word starts right after reset
         rx_par_valid <= 1'b0;
      end
      else
      begin
         sample_cnt   <= sample_cnt + 1'b1;  // wraps at eight
         rx_par_valid <= word_done;          // same edge as the word copy
      end
   end

   // each lane shifts toward the low byte, so the oldest sample ends up in byte 0
   always_ff @(posedge rx_lclk)
   begin
      lane_sh <= {rxi_data, lane_sh[ERX_WORD_BITS-ERX_LANES-1:ERX_LANES]};
      if (word_done)
      begin
         rx_data_par <= {rxi_data, lane_sh};  // live sample is byte 7
      end
   end

   //####################################################################
   // wait pins
   //####################################################################

   // fabric levels go out one cycle late, sender must stop on them
   always_ff @(posedge rx_lclk)
   begin
      if (!rst_n)
      begin
         rxo_wr_wait <= 1'b0;
         rxo_rd_wait <= 1'b0;
      end
      else
      begin
         rxo_wr_wait <= rx_wr_wait;
         rxo_rd_wait <= rx_rd_wait;
      end
   end

endmodule

//--- rtl/erx_pkg.sv
package erx_pkg;

   //####################################################################
   // link geometry
   //####################################################################
   localparam int ERX_LANES      = 8;                         // data lanes, one byte per sample
   localparam int ERX_WORD_BYTES = 8;                         // samples per lane per word
   localparam int ERX_WORD_BITS  = ERX_WORD_BYTES * ERX_LANES; // parallel word width
   localparam int ERX_CNT_BITS   = $clog2(ERX_WORD_BYTES);    // sample counter / byte offset

   // packet is header, 4 dstaddr bytes, 4 payload bytes, msb first
   localparam int ERX_PKT_BYTES  = 9;

   //####################################################################
   // header byte fields
   //####################################################################
   localparam int ERX_HDR_WRITE    = 7;  // 1 = write, 0 = read request
   localparam int ERX_HDR_DM_MSB   = 6;  // datamode
   localparam int ERX_HDR_DM_LSB   = 5;
   localparam int ERX_HDR_CTRL_MSB = 4;  // ctrlmode
   localparam int ERX_HDR_CTRL_LSB = 1;
   // bit 0 is reserved

   //####################################################################
   // payload views
   //####################################################################

   // source of a read request, where the read data goes back to
   typedef struct packed
   {
      logic [5:0]  src_row;     // core row
      logic [5:0]  src_col;     // core column
      logic [19:0] src_offset;  // offset inside the core
   } erx_rd_src_t;

   // payload word, write data or read source depending on the header
   typedef union packed
   {
      logic [31:0] wdata;
      erx_rd_src_t rd_src;
   } erx_payload_u;

endpackage

//--- rtl/erx_top.sv
`timescale 1ns/10ps

module erx_top
  (
   input  logic                          rx_lclk,
   input  logic                          rst_n,
   // link pins
   input  logic [erx_pkg::ERX_LANES-1:0] rxi_data,
   input  logic                          rxi_frame,
   output logic                          rxo_wr_wait,
   output logic                          rxo_rd_wait,
   // fabric wait levels
   input  logic                          rx_wr_wait,
   input  logic                          rx_rd_wait,
   // decoded transaction
   output logic                          rx_access,
   output logic                          rx_write,
   output logic [1:0]                    rx_datamode,
   output logic [3:0]                    rx_ctrlmode,
   output logic [31:0]                   rx_dstaddr,
   output logic [31:0]                   rx_wdata,
   output erx_pkg::erx_rd_src_t          rx_rd_src,
   output logic                          rx_frame_err
  );

   import erx_pkg::*;

   logic [ERX_WORD_BITS-1:0] rx_data_par;   // assembled word
   logic                     rx_par_valid;  // word boundary, counted only in erx_io
   logic                     pkt_start;
   logic [ERX_CNT_BITS-1:0]  pkt_off;

   //####################################################################
   // lanes and wait pins
   //####################################################################
   erx_io u_io
     (.rx_lclk      (rx_lclk),
      .rst_n        (rst_n),
      .rxi_data     (rxi_data),
      .rx_wr_wait   (rx_wr_wait),
      .rx_rd_wait   (rx_rd_wait),
      .rxo_wr_wait  (rxo_wr_wait),
      .rxo_rd_wait  (rxo_rd_wait),
      .rx_data_par  (rx_data_par),
      .rx_par_valid (rx_par_valid));

   // frame lane, aligned to the same word strobe
   erx_frame_detect u_frame
     (.rx_lclk      (rx_lclk),
      .rst_n        (rst_n),
      .rxi_frame    (rxi_frame),
      .rx_par_valid (rx_par_valid),
      .pkt_start    (pkt_start),
      .pkt_off      (pkt_off),
      .rx_frame_err (rx_frame_err));

   //####################################################################
   // packet decode
   //####################################################################
   erx_decoder u_dec
     (.rx_lclk      (rx_lclk),
      .rst_n        (rst_n),
      .rx_data_par  (rx_data_par),
      .rx_par_valid (rx_par_valid),
      .pkt_start    (pkt_start),
      .pkt_off      (pkt_off),
      .rx_access    (rx_access),
      .rx_write     (rx_write),
      .rx_datamode  (rx_datamode),
      .rx_ctrlmode  (rx_ctrlmode),
      .rx_dstaddr   (rx_dstaddr),
      .rx_wdata     (rx_wdata),
      .rx_rd_src    (rx_rd_src));

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the receiver testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=erx_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -f compile.f --top-module erx_tb \
   -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "sim passed" "$LOG_FILE"; then
   exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1

//--- verification/erx_properties.sv
`timescale 1ns/10ps

module erx_properties
  (
   input logic rx_lclk,
   input logic rst_n,
   input logic rx_par_valid,  // word strobe inside erx_top
   input logic pkt_start,
   input logic rx_access,
   input logic rx_frame_err,
   input logic rxo_wr_wait,
   input logic rxo_rd_wait
  );

   logic rst_seen = 1'b0;  // first reset edge has happened

   always @(posedge rx_lclk)
   begin
      if (!rst_n)
         rst_seen <= 1'b1;
   end

   // everything cleared by the reset edge before
   a_reset_low: assert property (@(posedge rx_lclk)
      rst_seen && $past(!rst_n) |-> !rx_access && !rx_frame_err && !rxo_wr_wait && !rxo_rd_wait)
      else $error("outputs not low after a reset cycle");

   // exactly one strobe in any eight cycles once two words are clear of reset
   a_word_period: assert property (@(posedge rx_lclk)
      $past(rst_n, 16) |-> $countones({rx_par_valid, $past(rx_par_valid, 1),
                                       $past(rx_par_valid, 2), $past(rx_par_valid, 3),
                                       $past(rx_par_valid, 4), $past(rx_par_valid, 5),
                                       $past(rx_par_valid, 6), $past(rx_par_valid, 7)}) == 1)
      else $error("rx_par_valid does not recur every 8 cycles");

   a_no_overlap: assert property (@(posedge rx_lclk)
      rst_seen |-> !(rx_access && rx_frame_err))
      else $error("rx_access and rx_frame_err high together");

   // decoder registers the start
   a_access_latency: assert property (@(posedge rx_lclk)
      rst_seen && $past(rst_n) |-> rx_access == $past(pkt_start))
      else $error("rx_access not exactly one cycle after pkt_start");

endmodule

bind erx_top erx_properties u_props
  (.rx_lclk      (rx_lclk),
   .rst_n        (rst_n),
   .rx_par_valid (rx_par_valid),
   .pkt_start    (pkt_start),
   .rx_access    (rx_access),
   .rx_frame_err (rx_frame_err),
   .rxo_wr_wait  (rxo_wr_wait),
   .rxo_rd_wait  (rxo_rd_wait));

//--- verification/erx_tb.sv
`timescale 1ns/10ps

module erx_tb;

   import erx_pkg::*;

   localparam int NUM_PKTS   = 400;
   localparam int MAX_GAP    = 12;   // longest run of low frame bytes between packets
   localparam int TAIL_BYTES = 32;   // idle bytes that flush the last packet out
   localparam int CLK_NS     = 4;
   localparam int MARGIN_NS  = 2000;
   // worst case is a full packet slot plus the longest gap, every time
   localparam int MAX_BYTES  = NUM_PKTS * (ERX_PKT_BYTES + MAX_GAP) + TAIL_BYTES;

   logic                 rx_lclk;
   logic                 rst_n;
   logic [ERX_LANES-1:0] rxi_data;
   logic                 rxi_frame;
   logic                 rx_wr_wait;
   logic                 rx_rd_wait;
   logic                 rxo_wr_wait;
   logic                 rxo_rd_wait;
   logic                 rx_access;
   logic                 rx_write;
   logic [1:0]           rx_datamode;
   logic [3:0]           rx_ctrlmode;
   logic [31:0]          rx_dstaddr;
   logic [31:0]          rx_wdata;
   erx_rd_src_t          rx_rd_src;
   logic                 rx_frame_err;

   // expected results, oldest packet first
   logic                 exp_is_err [$];  // 1 = short frame, no access
   logic [7:0]           exp_hdr    [$];
   logic [31:0]          exp_addr   [$];
   erx_payload_u         exp_pl     [$];

   int                   value_errs  = 0;
   int                   other_errs  = 0;
   int                   n_access    = 0;
   int                   n_frame_err = 0;
   int                   byte_idx    = 0;     // byte number since reset release
   logic [7:0]           off_seen    = '0;    // start offsets of complete packets
   logic                 last_wr     = 1'b0;  // wait levels driven one byte ago
   logic                 last_rd     = 1'b0;

   erx_top i_dut
     (.rx_lclk      (rx_lclk),
      .rst_n        (rst_n),
      .rxi_data     (rxi_data),
      .rxi_frame    (rxi_frame),
      .rxo_wr_wait  (rxo_wr_wait),
      .rxo_rd_wait  (rxo_rd_wait),
      .rx_wr_wait   (rx_wr_wait),
      .rx_rd_wait   (rx_rd_wait),
      .rx_access    (rx_access),
      .rx_write     (rx_write),
      .rx_datamode  (rx_datamode),
      .rx_ctrlmode  (rx_ctrlmode),
      .rx_dstaddr   (rx_dstaddr),
      .rx_wdata     (rx_wdata),
      .rx_rd_src    (rx_rd_src),
      .rx_frame_err (rx_frame_err));

   always #(CLK_NS / 2) rx_lclk = ~rx_lclk;

   //######################################################################
   // compare tasks
   //######################################################################

   task automatic report_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
      value_errs++;
      $display("FAIL %0t ns: %s expected %h, got %h", $time, name, exp, got);
   endtask

   task automatic check_wait(input logic exp_wr, input logic exp_rd);
      if (rxo_wr_wait !== exp_wr)
         report_value("rxo_wr_wait", 32'(exp_wr), 32'(rxo_wr_wait));
      if (rxo_rd_wait !== exp_rd)
         report_value("rxo_rd_wait", 32'(exp_rd), 32'(rxo_rd_wait));
   endtask

   task automatic check_frame_err(input logic exp_err);
      if (rx_frame_err !== exp_err)
         report_value("rx_frame_err", 32'(exp_err), 32'(rx_frame_err));
      if (rx_access !== 1'b0)
         report_value("rx_access", 32'h0, 32'(rx_access));  // short frame must not decode
   endtask

   task automatic check_access(input erx_payload_u exp_payload, input logic exp_write,
                               input logic [1:0] exp_dm, input logic [3:0] exp_cm,
                               input logic [31:0] exp_dstaddr);
      if (rx_access !== 1'b1)
         report_value("rx_access", 32'h1, 32'(rx_access));
      if (rx_frame_err !== 1'b0)
         report_value("rx_frame_err", 32'h0, 32'(rx_frame_err));
      if (rx_write !== exp_write)
         report_value("rx_write", 32'(exp_write), 32'(rx_write));
      if (rx_datamode !== exp_dm)
         report_value("rx_datamode", 32'(exp_dm), 32'(rx_datamode));
      if (rx_ctrlmode !== exp_cm)
         report_value("rx_ctrlmode", 32'(exp_cm), 32'(rx_ctrlmode));
      if (rx_dstaddr !== exp_dstaddr)
         report_value("rx_dstaddr", exp_dstaddr, rx_dstaddr);
      if (exp_write)
      begin
         if (rx_wdata !== exp_payload.wdata)
            report_value("rx_wdata", exp_payload.wdata, rx_wdata);
         if (rx_rd_src !== '0)
            report_value("rx_rd_src", 32'h0, 32'(rx_rd_src));  // cleared on writes
      end
      else
      begin
         if (rx_rd_src.src_row !== exp_payload.rd_src.src_row)
            report_value("rx_rd_src.src_row", 32'(exp_payload.rd_src.src_row),
                         32'(rx_rd_src.src_row));
         if (rx_rd_src.src_col !== exp_payload.rd_src.src_col)
            report_value("rx_rd_src.src_col", 32'(exp_payload.rd_src.src_col),
                         32'(rx_rd_src.src_col));
         if (rx_rd_src.src_offset !== exp_payload.rd_src.src_offset)
            report_value("rx_rd_src.src_offset", 32'(exp_payload.rd_src.src_offset),
                         32'(rx_rd_src.src_offset));
         if (rx_wdata !== 32'h0)
            report_value("rx_wdata", 32'h0, rx_wdata);  // cleared on reads
      end
   endtask

   //######################################################################
   // reference model and link driver
   //######################################################################

   // header bit 7 picks the view, reads split into row, col, offset
   function automatic erx_payload_u model_payload(input logic [7:0] hdr,
                                                  input logic [31:0] pl);
      erx_payload_u view;
      view.wdata = pl;
      if (!hdr[7])
      begin
         view.rd_src.src_row    = pl[31:26];
         view.rd_src.src_col    = pl[25:20];
         view.rd_src.src_offset = pl[19:0];
      end
      return view;
   endfunction

   // one sample per cycle, waits toggle at random under the traffic
   task automatic send_byte(input logic [7:0] data, input logic frame);
      @(negedge rx_lclk);
      check_wait(last_wr, last_rd);  // levels taken at the edge just passed
      rxi_data   = data;
      rxi_frame  = frame;
      last_wr    = 1'($urandom_range(0, 1));
      last_rd    = 1'($urandom_range(0, 1));
      rx_wr_wait = last_wr;
      rx_rd_wait = last_rd;
      byte_idx++;
   endtask

   // nine byte slots, frame high only for the first keep of them
   task automatic send_packet(input logic [7:0] hdr, input logic [31:0] addr,
                              input logic [31:0] pl, input int keep);
      logic [7:0] pkt [ERX_PKT_BYTES];
      pkt[0] = hdr;
      for (int b = 0; b < 4; b++)
      begin
         pkt[1+b] = addr[31-8*b -: 8];  // msb first
         pkt[5+b] = pl[31-8*b -: 8];
      end
      for (int i = 0; i < ERX_PKT_BYTES; i++)
         send_byte(pkt[i], i < keep);
   endtask

   //######################################################################
   // stimulus, monitor, watchdog
   //######################################################################

   initial
   begin
      logic [7:0]  hdr;
      logic [31:0] addr;
      logic [31:0] pl;
      int          gap;
      int          keep;
      void'($urandom(32'h4cb1_94f6));
      rx_lclk    = 1'b0;
      rst_n      = 1'b0;
      rxi_data   = '0;
      rxi_frame  = 1'b0;
      rx_wr_wait = 1'b0;
      rx_rd_wait = 1'b0;
      repeat (3) @(posedge rx_lclk);
      @(negedge rx_lclk);
      rst_n    = 1'b1;
      byte_idx = 1;  // the idle byte driven here is byte 0 of the first word
      for (int p = 0; p < NUM_PKTS; p++)
      begin
         hdr  = 8'($urandom);
         addr = $urandom;
         pl   = $urandom;
         gap  = int'($urandom_range(1, MAX_GAP));
         keep = ($urandom_range(0, 9) == 0) ? int'($urandom_range(1, 8)) : ERX_PKT_BYTES;
         exp_is_err.push_back(keep < ERX_PKT_BYTES);
         exp_hdr.push_back(hdr);
         exp_addr.push_back(addr);
         exp_pl.push_back(model_payload(hdr, pl));
         if (keep == ERX_PKT_BYTES)
            off_seen[byte_idx % ERX_WORD_BYTES] = 1'b1;
         send_packet(hdr, addr, pl, keep);
         repeat (gap) send_byte(8'($urandom), 1'b0);  // idle data must be ignored
      end
      repeat (TAIL_BYTES) send_byte(8'($urandom), 1'b0);
      if (exp_is_err.size() != 0)
      begin
         other_errs++;
         $display("%0d expected results never came out of the DUT", exp_is_err.size());
      end
      for (int k = 0; k < ERX_WORD_BYTES; k++)
      begin
         if (!off_seen[k])
         begin
            other_errs++;
            $display("no complete packet was sent starting at byte offset %0d", k);
         end
      end
      $display("errors: %0d value, %0d other (%0d accesses, %0d frame errors seen)",
               value_errs, other_errs, n_access, n_frame_err);
      if (value_errs + other_errs == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   // outputs settle at the rising edge, looked at on the falling one
   always @(negedge rx_lclk)
   begin : monitor
      logic [7:0] hdr;
      if (rx_access === 1'b1 || rx_frame_err === 1'b1)
      begin
         if (exp_is_err.size() == 0)
         begin
            other_errs++;
            $display("%0t ns: DUT gave a result that no sent packet accounts for", $time);
         end
         else
         begin
            hdr = exp_hdr[0];
            if (exp_is_err[0])
            begin
               check_frame_err(1'b1);
               n_frame_err++;
            end
            else
            begin
               check_access(exp_pl[0], hdr[7], hdr[6:5], hdr[4:1], exp_addr[0]);
               n_access++;
            end
            void'(exp_is_err.pop_front());
            void'(exp_hdr.pop_front());
            void'(exp_addr.pop_front());
            void'(exp_pl.pop_front());
         end
      end
   end

   initial
   begin
      #(MAX_BYTES * CLK_NS + MARGIN_NS);
      $display("run timed out at %0t ns with %0d results still outstanding",
               $time, exp_is_err.size());
      $display("sim failed");
      $finish;
   end

endmodule
